//--- decode_pkg.sv
// Memory decode package
// Shared encodings for the memory-instruction decode stage of the RV32 core
// Major opcodes, AMO selectors, A extension support and operand C select
package decode_pkg;

  ////////////////////////////////////////
  // Widths and fixed field values
  ////////////////////////////////////////

  // Instruction word width
  localparam int unsigned INSTR_W = 32;

  // Atomic op code, top bit marks an atomic, low bits are funct5
  localparam int unsigned ATOP_W = 6;

  // funct3 for word sized atomics
  localparam logic [2:0] FUNCT3_WORD = 3'b010;

  ////////////////////////////////////////
  // Opcodes and selectors
  ////////////////////////////////////////

  // Major opcodes handled by this stage
  typedef enum logic [6:0] {
    OPCODE_LOAD  = 7'h03,
    OPCODE_STORE = 7'h23,
    OPCODE_AMO   = 7'h2f
  } opcode_e;

  // AMO selector in bits 31:27
  typedef enum logic [4:0] {
    AMO_LR   = 5'b00010,
    AMO_SC   = 5'b00011,
    AMO_SWAP = 5'b00001,
    AMO_ADD  = 5'b00000,
    AMO_XOR  = 5'b00100,
    AMO_AND  = 5'b01100,
    AMO_OR   = 5'b01000,
    AMO_MIN  = 5'b10000,
    AMO_MAX  = 5'b10100,
    AMO_MINU = 5'b11000,
    AMO_MAXU = 5'b11100
  } amo_funct5_e;

  // Level of A extension support
  typedef enum logic [1:0] {
    A_NONE = 2'b00,
    ZALRSC = 2'b01,
    A      = 2'b10
  } a_ext_e;

  // Operand C source, rs2 carries the store data
  typedef enum logic {
    OP_C_NONE = 1'b0,
    OP_C_REGB = 1'b1
  } op_c_sel_e;

endpackage

//--- a_decoder.sv
// Atomic decoder
// Decodes RV32A word atomics, LR, SC and the nine AMO operations
// The A_EXT parameter limits support to full A, LR/SC only or none
// Words that are not accepted give legal low and all controls zero
`timescale 1ns/1ps

module a_decoder #(
  parameter decode_pkg::a_ext_e A_EXT = decode_pkg::A
) (
  input  logic [decode_pkg::INSTR_W-1:0] instr_rdata_i,
  output logic                           legal_o,
  output logic                           lsu_we_o,
  output logic [1:0]                     lsu_size_o,
  output logic                           lsu_sext_o,
  output logic [decode_pkg::ATOP_W-1:0]  lsu_atop_o,
  output logic [1:0]                     rf_re_o,
  output logic                           rf_we_o,
  output decode_pkg::op_c_sel_e          op_c_sel_o
);
  import decode_pkg::*;

  // Parts of A that are built in
  localparam bit LRSC_EN = (A_EXT == A) || (A_EXT == ZALRSC);
  localparam bit AMO_EN  = (A_EXT == A);

  logic       is_word_amo;
  logic       legal;
  logic       uses_rs2;
  logic [4:0] funct5;

  // Operation selector
  assign funct5 = instr_rdata_i[31:27];

  // AMO opcode with word funct3
  assign is_word_amo = (instr_rdata_i[6:0] == OPCODE_AMO) &&
                       (instr_rdata_i[14:12] == FUNCT3_WORD);

  ////////////////////////////////////////
  // Operation select
  ////////////////////////////////////////

  always_comb begin
    legal    = 1'b0;
    uses_rs2 = 1'b0;
    if (is_word_amo) begin
      case (funct5)
        AMO_LR: begin
          // rs2 field is reserved for LR, must be zero
          legal = LRSC_EN && (instr_rdata_i[24:20] == 5'd0);
        end
        AMO_SC: begin
          legal    = LRSC_EN;
          uses_rs2 = 1'b1;
        end
        AMO_SWAP,
        AMO_ADD,
        AMO_XOR,
        AMO_AND,
        AMO_OR,
        AMO_MIN,
        AMO_MAX,
        AMO_MINU,
        AMO_MAXU: begin
          legal    = AMO_EN;
          uses_rs2 = 1'b1;
        end
        default: begin
          // Reserved funct5
          legal = 1'b0;
        end
      endcase
    end
  end

  ////////////////////////////////////////
  // Control outputs
  ////////////////////////////////////////

  assign legal_o = legal;

  // SC and AMOs write memory with rs2 as data
  assign lsu_we_o   = legal & uses_rs2;
  assign op_c_sel_o = (legal && uses_rs2) ? OP_C_REGB : OP_C_NONE;

  // All atomics are sign extended word accesses
  assign lsu_size_o = legal ? 2'b10 : 2'b00;
  assign lsu_sext_o = legal;

  // Atomic bit plus funct5
  assign lsu_atop_o = legal ? {1'b1, funct5} : '0;

  // rs1 is the address, rs2 only when data is written
  assign rf_re_o = legal ? {uses_rs2, 1'b1} : 2'b00;

  // Every atomic returns a value to rd
  assign rf_we_o = legal;

endmodule

//--- ls_decoder.sv
// Load/store decoder
// Decodes the RV32I LOAD and STORE opcodes
// Sets access size, sign extension and register use
// Unused funct3 values and other opcodes are not legal
`timescale 1ns/1ps

module ls_decoder (
  input  logic [decode_pkg::INSTR_W-1:0] instr_rdata_i,
  output logic                           legal_o,
  output logic                           lsu_we_o,
  output logic [1:0]                     lsu_size_o,
  output logic                           lsu_sext_o,
  output logic [decode_pkg::ATOP_W-1:0]  lsu_atop_o,
  output logic [1:0]                     rf_re_o,
  output logic                           rf_we_o,
  output decode_pkg::op_c_sel_e          op_c_sel_o
);
  import decode_pkg::*;

  logic [2:0] funct3;

  assign funct3 = instr_rdata_i[14:12];

  // Plain loads and stores are never atomic
  assign lsu_atop_o = '0;

  always_comb begin
    // Default is no match
    legal_o    = 1'b0;
    lsu_we_o   = 1'b0;
    lsu_size_o = 2'b00;
    lsu_sext_o = 1'b0;
    rf_re_o    = 2'b00;
    rf_we_o    = 1'b0;
    op_c_sel_o = OP_C_NONE;

    if (instr_rdata_i[6:0] == OPCODE_LOAD) begin
      // LB LH LW LBU LHU
      case (funct3)
        3'b000, 3'b001, 3'b010, 3'b100, 3'b101: begin
          legal_o    = 1'b1;
          lsu_size_o = funct3[1:0];
          // Unsigned forms have funct3[2] set
          lsu_sext_o = ~funct3[2];
          rf_re_o    = 2'b01;
          rf_we_o    = 1'b1;
        end
        default: begin
          legal_o = 1'b0;
        end
      endcase
    end else if (instr_rdata_i[6:0] == OPCODE_STORE) begin
      // SB SH SW
      case (funct3)
        3'b000, 3'b001, 3'b010: begin
          legal_o    = 1'b1;
          lsu_we_o   = 1'b1;
          lsu_size_o = funct3[1:0];
          // rs1 address, rs2 store data
          rf_re_o    = 2'b11;
          op_c_sel_o = OP_C_REGB;
        end
        default: begin
          legal_o = 1'b0;
        end
      endcase
    end
  end

endmodule

//--- decoder_merge.sv
// Decoder merge
// Picks the legal result of the atomic and load/store decoders
// Flags illegal words, extracts the register addresses in use
// and drops register writes to x0
`timescale 1ns/1ps

module decoder_merge (
  input  logic [decode_pkg::INSTR_W-1:0] instr_rdata_i,
  // Atomic decoder
  input  logic                           a_legal_i,
  input  logic                           a_lsu_we_i,
  input  logic [1:0]                     a_lsu_size_i,
  input  logic                           a_lsu_sext_i,
  input  logic [decode_pkg::ATOP_W-1:0]  a_lsu_atop_i,
  input  logic [1:0]                     a_rf_re_i,
  input  logic                           a_rf_we_i,
  input  decode_pkg::op_c_sel_e          a_op_c_sel_i,
  // Load/store decoder
  input  logic                           ls_legal_i,
  input  logic                           ls_lsu_we_i,
  input  logic [1:0]                     ls_lsu_size_i,
  input  logic                           ls_lsu_sext_i,
  input  logic [decode_pkg::ATOP_W-1:0]  ls_lsu_atop_i,
  input  logic [1:0]                     ls_rf_re_i,
  input  logic                           ls_rf_we_i,
  input  decode_pkg::op_c_sel_e          ls_op_c_sel_i,
  // Merged word
  output logic                           illegal_o,
  output logic                           lsu_en_o,
  output logic                           lsu_we_o,
  output logic [1:0]                     lsu_size_o,
  output logic                           lsu_sext_o,
  output logic [decode_pkg::ATOP_W-1:0]  lsu_atop_o,
  output logic [1:0]                     rf_re_o,
  output logic                           rf_we_o,
  output decode_pkg::op_c_sel_e          op_c_sel_o,
  output logic [4:0]                     rs1_o,
  output logic [4:0]                     rs2_o,
  output logic [4:0]                     rd_o
);
  import decode_pkg::*;

  logic       rf_we;
  logic [4:0] rd_field;

  assign rd_field = instr_rdata_i[11:7];

  ////////////////////////////////////////
  // Result select
  ////////////////////////////////////////

  always_comb begin
    lsu_we_o   = 1'b0;
    lsu_size_o = 2'b00;
    lsu_sext_o = 1'b0;
    lsu_atop_o = '0;
    rf_re_o    = 2'b00;
    rf_we      = 1'b0;
    op_c_sel_o = OP_C_NONE;
    if (a_legal_i) begin
      lsu_we_o   = a_lsu_we_i;
      lsu_size_o = a_lsu_size_i;
      lsu_sext_o = a_lsu_sext_i;
      lsu_atop_o = a_lsu_atop_i;
      rf_re_o    = a_rf_re_i;
      rf_we      = a_rf_we_i;
      op_c_sel_o = a_op_c_sel_i;
    end else if (ls_legal_i) begin
      lsu_we_o   = ls_lsu_we_i;
      lsu_size_o = ls_lsu_size_i;
      lsu_sext_o = ls_lsu_sext_i;
      lsu_atop_o = ls_lsu_atop_i;
      rf_re_o    = ls_rf_re_i;
      rf_we      = ls_rf_we_i;
      op_c_sel_o = ls_op_c_sel_i;
    end
  end

  // Neither decoder claims the word
  assign lsu_en_o  = a_legal_i | ls_legal_i;
  assign illegal_o = ~lsu_en_o;

  ////////////////////////////////////////
  // Register addresses
  ////////////////////////////////////////

  // Writes to x0 are dropped
  assign rf_we_o = rf_we && (rd_field != 5'd0);

  // Fields that are not used read as zero
  assign rs1_o = rf_re_o[0] ? instr_rdata_i[19:15] : 5'd0;
  assign rs2_o = rf_re_o[1] ? instr_rdata_i[24:20] : 5'd0;
  assign rd_o  = rf_we_o    ? rd_field             : 5'd0;

endmodule

//--- id_mem_reg.sv
// ID to EX register
// Single-entry valid/ready stage holding the decoded control word
// Accepts a new word each cycle while the output is being taken
`timescale 1ns/1ps

module id_mem_reg (
  input  logic                          clk,
  input  logic                          arst_n_i,
  // Upstream side
  input  logic                          in_valid_i,
  output logic                          in_ready_o,
  input  logic                          illegal_i,
  input  logic                          lsu_en_i,
  input  logic                          lsu_we_i,
  input  logic [1:0]                    lsu_size_i,
  input  logic                          lsu_sext_i,
  input  logic [decode_pkg::ATOP_W-1:0] lsu_atop_i,
  input  logic [1:0]                    rf_re_i,
  input  logic                          rf_we_i,
  input  decode_pkg::op_c_sel_e         op_c_sel_i,
  input  logic [4:0]                    rs1_i,
  input  logic [4:0]                    rs2_i,
  input  logic [4:0]                    rd_i,
  // Execute side
  output logic                          out_valid_o,
  input  logic                          out_ready_i,
  output logic                          illegal_o,
  output logic                          lsu_en_o,
  output logic                          lsu_we_o,
  output logic [1:0]                    lsu_size_o,
  output logic                          lsu_sext_o,
  output logic [decode_pkg::ATOP_W-1:0] lsu_atop_o,
  output logic [1:0]                    rf_re_o,
  output logic                          rf_we_o,
  output decode_pkg::op_c_sel_e         op_c_sel_o,
  output logic [4:0]                    rs1_o,
  output logic [4:0]                    rs2_o,
  output logic [4:0]                    rd_o
);
  import decode_pkg::*;

  logic load;

  // Free when empty or the held word leaves this cycle
  assign in_ready_o = ~out_valid_o | out_ready_i;
  assign load       = in_valid_i & in_ready_o;

  ////////////////////////////////////////
  // Valid flag
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      out_valid_o <= 1'b0;
    end else if (load) begin
      out_valid_o <= 1'b1;
    end else if (out_ready_i) begin
      // Taken with nothing behind it
      out_valid_o <= 1'b0;
    end
  end

  ////////////////////////////////////////
  // Control word
  ////////////////////////////////////////

  // Cleared on reset so the outputs start at zero
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      illegal_o  <= 1'b0;
      lsu_en_o   <= 1'b0;
      lsu_we_o   <= 1'b0;
      lsu_size_o <= 2'b00;
      lsu_sext_o <= 1'b0;
      lsu_atop_o <= '0;
      rf_re_o    <= 2'b00;
      rf_we_o    <= 1'b0;
      op_c_sel_o <= OP_C_NONE;
      rs1_o      <= 5'd0;
      rs2_o      <= 5'd0;
      rd_o       <= 5'd0;
    end else if (load) begin
      illegal_o  <= illegal_i;
      lsu_en_o   <= lsu_en_i;
      lsu_we_o   <= lsu_we_i;
      lsu_size_o <= lsu_size_i;
      lsu_sext_o <= lsu_sext_i;
      lsu_atop_o <= lsu_atop_i;
      rf_re_o    <= rf_re_i;
      rf_we_o    <= rf_we_i;
      op_c_sel_o <= op_c_sel_i;
      rs1_o      <= rs1_i;
      rs2_o      <= rs2_i;
      rd_o       <= rd_i;
    end
  end

endmodule

//--- mem_decode_top.sv
// Memory-instruction decode top
// Atomic and load/store decoders in parallel, a merge block,
// then one pipeline register toward the execute stage
`timescale 1ns/1ps

module mem_decode_top #(
  parameter decode_pkg::a_ext_e A_EXT = decode_pkg::A
) (
  input  logic                           clk,
  input  logic                           arst_n_i,
  input  logic                           instr_valid_i,
  output logic                           instr_ready_o,
  input  logic [decode_pkg::INSTR_W-1:0] instr_rdata_i,
  output logic                           out_valid_o,
  input  logic                           out_ready_i,
  output logic                           illegal_o,
  output logic                           lsu_en_o,
  output logic                           lsu_we_o,
  output logic [1:0]                     lsu_size_o,
  output logic                           lsu_sext_o,
  output logic [decode_pkg::ATOP_W-1:0]  lsu_atop_o,
  output logic [1:0]                     rf_re_o,
  output logic                           rf_we_o,
  output decode_pkg::op_c_sel_e          op_c_sel_o,
  output logic [4:0]                     rs1_o,
  output logic [4:0]                     rs2_o,
  output logic [4:0]                     rd_o
);
  import decode_pkg::*;

  ////////////////////////////////////////
  // Decoder results
  ////////////////////////////////////////

  // Atomic decoder
  logic              a_legal, a_lsu_we, a_lsu_sext, a_rf_we;
  logic [1:0]        a_lsu_size, a_rf_re;
  logic [ATOP_W-1:0] a_lsu_atop;
  op_c_sel_e         a_op_c_sel;

  // Load/store decoder
  logic              ls_legal, ls_lsu_we, ls_lsu_sext, ls_rf_we;
  logic [1:0]        ls_lsu_size, ls_rf_re;
  logic [ATOP_W-1:0] ls_lsu_atop;
  op_c_sel_e         ls_op_c_sel;

  // Merged word into the register
  logic              m_illegal, m_lsu_en, m_lsu_we, m_lsu_sext, m_rf_we;
  logic [1:0]        m_lsu_size, m_rf_re;
  logic [ATOP_W-1:0] m_lsu_atop;
  op_c_sel_e         m_op_c_sel;
  logic [4:0]        m_rs1, m_rs2, m_rd;

  a_decoder #(
    .A_EXT (A_EXT)
  ) u_a_decoder (
    .instr_rdata_i (instr_rdata_i),
    .legal_o       (a_legal),
    .lsu_we_o      (a_lsu_we),
    .lsu_size_o    (a_lsu_size),
    .lsu_sext_o    (a_lsu_sext),
    .lsu_atop_o    (a_lsu_atop),
    .rf_re_o       (a_rf_re),
    .rf_we_o       (a_rf_we),
    .op_c_sel_o    (a_op_c_sel)
  );

  ls_decoder u_ls_decoder (
    .instr_rdata_i (instr_rdata_i),
    .legal_o       (ls_legal),
    .lsu_we_o      (ls_lsu_we),
    .lsu_size_o    (ls_lsu_size),
    .lsu_sext_o    (ls_lsu_sext),
    .lsu_atop_o    (ls_lsu_atop),
    .rf_re_o       (ls_rf_re),
    .rf_we_o       (ls_rf_we),
    .op_c_sel_o    (ls_op_c_sel)
  );

  ////////////////////////////////////////
  // Merge and pipeline register
  ////////////////////////////////////////

  decoder_merge u_decoder_merge (
    .instr_rdata_i (instr_rdata_i),
    .a_legal_i     (a_legal),
    .a_lsu_we_i    (a_lsu_we),
    .a_lsu_size_i  (a_lsu_size),
    .a_lsu_sext_i  (a_lsu_sext),
    .a_lsu_atop_i  (a_lsu_atop),
    .a_rf_re_i     (a_rf_re),
    .a_rf_we_i     (a_rf_we),
    .a_op_c_sel_i  (a_op_c_sel),
    .ls_legal_i    (ls_legal),
    .ls_lsu_we_i   (ls_lsu_we),
    .ls_lsu_size_i (ls_lsu_size),
    .ls_lsu_sext_i (ls_lsu_sext),
    .ls_lsu_atop_i (ls_lsu_atop),
    .ls_rf_re_i    (ls_rf_re),
    .ls_rf_we_i    (ls_rf_we),
    .ls_op_c_sel_i (ls_op_c_sel),
    .illegal_o     (m_illegal),
    .lsu_en_o      (m_lsu_en),
    .lsu_we_o      (m_lsu_we),
    .lsu_size_o    (m_lsu_size),
    .lsu_sext_o    (m_lsu_sext),
    .lsu_atop_o    (m_lsu_atop),
    .rf_re_o       (m_rf_re),
    .rf_we_o       (m_rf_we),
    .op_c_sel_o    (m_op_c_sel),
    .rs1_o         (m_rs1),
    .rs2_o         (m_rs2),
    .rd_o          (m_rd)
  );

  id_mem_reg u_id_mem_reg (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .in_valid_i  (instr_valid_i),
    .in_ready_o  (instr_ready_o),
    .illegal_i   (m_illegal),
    .lsu_en_i    (m_lsu_en),
    .lsu_we_i    (m_lsu_we),
    .lsu_size_i  (m_lsu_size),
    .lsu_sext_i  (m_lsu_sext),
    .lsu_atop_i  (m_lsu_atop),
    .rf_re_i     (m_rf_re),
    .rf_we_i     (m_rf_we),
    .op_c_sel_i  (m_op_c_sel),
    .rs1_i       (m_rs1),
    .rs2_i       (m_rs2),
    .rd_i        (m_rd),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .illegal_o   (illegal_o),
    .lsu_en_o    (lsu_en_o),
    .lsu_we_o    (lsu_we_o),
    .lsu_size_o  (lsu_size_o),
    .lsu_sext_o  (lsu_sext_o),
    .lsu_atop_o  (lsu_atop_o),
    .rf_re_o     (rf_re_o),
    .rf_we_o     (rf_we_o),
    .op_c_sel_o  (op_c_sel_o),
    .rs1_o       (rs1_o),
    .rs2_o       (rs2_o),
    .rd_o        (rd_o)
  );

endmodule

//--- tb_decode_ref.svh
// Reference decode for the memory-instruction decode stage
// Builds the expected control word from one instruction word
// Word layout from bit 30 down: illegal, lsu_en, lsu_we, lsu_size,
// lsu_sext, lsu_atop, rf_re, rf_we, op_c_sel, rs1, rs2, rd
`ifndef TB_DECODE_REF_SVH
`define TB_DECODE_REF_SVH

// SC and the nine read-modify-write AMOs, RV32A funct5 codes
function automatic logic is_rmw_amo(input logic [4:0] f5);
  case (f5)
    5'b00011, 5'b00001, 5'b00000, 5'b00100, 5'b01100,
    5'b01000, 5'b10000, 5'b10100, 5'b11000, 5'b11100: return 1'b1;
    default: return 1'b0;
  endcase
endfunction

function automatic logic [30:0] decode_ref(input logic [31:0] w);
  logic [2:0] f3;
  logic [4:0] f5;
  logic       legal;
  logic       rmw;
  logic       we;
  logic       sext;
  logic       wr;
  logic       opc_c;
  logic [1:0] size;
  logic [1:0] re;
  logic [5:0] atop;
  logic [4:0] rs1;
  logic [4:0] rs2;
  logic [4:0] rd;
  f3    = w[14:12];
  f5    = w[31:27];
  legal = 1'b0;
  rmw   = 1'b0;
  we    = 1'b0;
  sext  = 1'b0;
  wr    = 1'b0;
  opc_c = 1'b0;
  size  = 2'b00;
  re    = 2'b00;
  atop  = 6'd0;
  case (w[6:0])
    7'h2f: begin
      // Word atomics only, LR needs a zero rs2 field
      if (f3 == 3'b010) begin
        rmw   = is_rmw_amo(f5);
        legal = rmw || ((f5 == 5'b00010) && (w[24:20] == 5'd0));
      end
      if (legal) begin
        size  = 2'b10;
        sext  = 1'b1;
        atop  = {1'b1, f5};
        wr    = 1'b1;
        re    = rmw ? 2'b11 : 2'b01;
        we    = rmw;
        opc_c = rmw;
      end
    end
    7'h03: begin
      // LB LH LW sign extend, LBU LHU zero extend
      case (f3)
        3'b000: begin
          legal = 1'b1;
          size  = 2'b00;
          sext  = 1'b1;
        end
        3'b001: begin
          legal = 1'b1;
          size  = 2'b01;
          sext  = 1'b1;
        end
        3'b010: begin
          legal = 1'b1;
          size  = 2'b10;
          sext  = 1'b1;
        end
        3'b100: begin
          legal = 1'b1;
          size  = 2'b00;
        end
        3'b101: begin
          legal = 1'b1;
          size  = 2'b01;
        end
        default: legal = 1'b0;
      endcase
      if (legal) begin
        re = 2'b01;
        wr = 1'b1;
      end
    end
    7'h23: begin
      // SB SH SW, rs2 is the store data
      case (f3)
        3'b000: begin
          legal = 1'b1;
          size  = 2'b00;
        end
        3'b001: begin
          legal = 1'b1;
          size  = 2'b01;
        end
        3'b010: begin
          legal = 1'b1;
          size  = 2'b10;
        end
        default: legal = 1'b0;
      endcase
      if (legal) begin
        we    = 1'b1;
        re    = 2'b11;
        opc_c = 1'b1;
      end
    end
    default: legal = 1'b0;
  endcase
  // No write to x0
  if (w[11:7] == 5'd0) begin
    wr = 1'b0;
  end
  rs1 = re[0] ? w[19:15] : 5'd0;
  rs2 = re[1] ? w[24:20] : 5'd0;
  rd  = wr ? w[11:7] : 5'd0;
  return {~legal, legal, we, size, sext, atop, re, wr, opc_c, rs1, rs2, rd};
endfunction

`endif

//--- tb_mem_decode_top.sv
// Testbench for the memory-instruction decode stage
// Directed and random instruction words under random valid and ready,
// expected control words from a reference decode, checked in order
`timescale 1ns/1ps

module tb_mem_decode_top;
  import decode_pkg::*;

  `include "tb_decode_ref.svh"

  logic              clk;
  logic              arst_n;
  logic              instr_valid;
  logic              instr_ready;
  logic [31:0]       instr_rdata;
  logic              out_valid;
  logic              out_ready;
  logic              illegal;
  logic              lsu_en;
  logic              lsu_we;
  logic [1:0]        lsu_size;
  logic              lsu_sext;
  logic [ATOP_W-1:0] lsu_atop;
  logic [1:0]        rf_re;
  logic              rf_we;
  op_c_sel_e         op_c_sel;
  logic [4:0]        rs1;
  logic [4:0]        rs2;
  logic [4:0]        rd;
  logic [30:0]       out_word;

  // Stimulus, expected words and bookkeeping
  logic [31:0] stim_q[$];
  string       stim_name_q[$];
  logic [30:0] exp_q[$];
  string       name_q[$];
  int          errors = 0;
  int          checks = 0;
  int          cycles = 0;
  int          cycle_limit = 0;
  logic        hold_pending = 1'b0;
  logic [30:0] hold_word;

  mem_decode_top #(
    .A_EXT (A)
  ) uut (
    .clk           (clk),
    .arst_n_i      (arst_n),
    .instr_valid_i (instr_valid),
    .instr_ready_o (instr_ready),
    .instr_rdata_i (instr_rdata),
    .out_valid_o   (out_valid),
    .out_ready_i   (out_ready),
    .illegal_o     (illegal),
    .lsu_en_o      (lsu_en),
    .lsu_we_o      (lsu_we),
    .lsu_size_o    (lsu_size),
    .lsu_sext_o    (lsu_sext),
    .lsu_atop_o    (lsu_atop),
    .rf_re_o       (rf_re),
    .rf_we_o       (rf_we),
    .op_c_sel_o    (op_c_sel),
    .rs1_o         (rs1),
    .rs2_o         (rs2),
    .rd_o          (rd)
  );

  // Same layout as the reference word
  assign out_word = {illegal, lsu_en, lsu_we, lsu_size, lsu_sext, lsu_atop,
                     rf_re, rf_we, op_c_sel, rs1, rs2, rd};

  initial begin
    clk = 1'b0;
    forever begin
      #5 clk = ~clk;
    end
  end

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  task automatic check_val(input string tname, input string fname,
                           input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("ERR %s %s expected %0h actual %0h", tname, fname, exp, act);
    end
  endtask

  function automatic logic [31:0] field_of(input logic [30:0] w, input int lo, input int wid);
    return (32'(w) >> lo) & ((32'd1 << wid) - 32'd1);
  endfunction

  // One check per control field
  task automatic compare_word(input string tname, input logic [30:0] exp,
                              input logic [30:0] act);
    check_val(tname, "illegal", field_of(exp, 30, 1), field_of(act, 30, 1));
    check_val(tname, "lsu_en", field_of(exp, 29, 1), field_of(act, 29, 1));
    check_val(tname, "lsu_we", field_of(exp, 28, 1), field_of(act, 28, 1));
    check_val(tname, "lsu_size", field_of(exp, 26, 2), field_of(act, 26, 2));
    check_val(tname, "lsu_sext", field_of(exp, 25, 1), field_of(act, 25, 1));
    check_val(tname, "lsu_atop", field_of(exp, 19, 6), field_of(act, 19, 6));
    check_val(tname, "rf_re", field_of(exp, 17, 2), field_of(act, 17, 2));
    check_val(tname, "rf_we", field_of(exp, 16, 1), field_of(act, 16, 1));
    check_val(tname, "op_c_sel", field_of(exp, 15, 1), field_of(act, 15, 1));
    check_val(tname, "rs1", field_of(exp, 10, 5), field_of(act, 10, 5));
    check_val(tname, "rs2", field_of(exp, 5, 5), field_of(act, 5, 5));
    check_val(tname, "rd", field_of(exp, 0, 5), field_of(act, 0, 5));
  endtask

  ////////////////////////////////////////
  // Instruction words
  ////////////////////////////////////////

  // SC first, then the nine AMOs, LR at the end
  function automatic logic [4:0] amo_funct5(input int k);
    case (k)
      0: return 5'b00011;
      1: return 5'b00001;
      2: return 5'b00000;
      3: return 5'b00100;
      4: return 5'b01100;
      5: return 5'b01000;
      6: return 5'b10000;
      7: return 5'b10100;
      8: return 5'b11000;
      9: return 5'b11100;
      default: return 5'b00010;
    endcase
  endfunction

  function automatic logic [31:0] make_amo(input logic [4:0] f5, input logic [4:0] rs2_f,
      input logic [4:0] rs1_f, input logic [2:0] f3, input logic [4:0] rd_f);
    return {f5, 2'b01, rs2_f, rs1_f, f3, rd_f, 7'h2f};
  endfunction

  function automatic logic [31:0] make_load(input logic [11:0] imm, input logic [4:0] rs1_f,
      input logic [2:0] f3, input logic [4:0] rd_f);
    return {imm, rs1_f, f3, rd_f, 7'h03};
  endfunction

  function automatic logic [31:0] make_store(input logic [11:0] imm, input logic [4:0] rs2_f,
      input logic [4:0] rs1_f, input logic [2:0] f3);
    return {imm[11:5], rs2_f, rs1_f, f3, imm[4:0], 7'h23};
  endfunction

  task automatic queue_word(input logic [31:0] w, input string tname);
    stim_q.push_back(w);
    stim_name_q.push_back(tname);
  endtask

  task automatic build_directed();
    // LR legal only with rs2 zero
    queue_word(make_amo(5'b00010, 5'd0, 5'd6, 3'b010, 5'd5), "lr");
    queue_word(make_amo(5'b00010, 5'd3, 5'd6, 3'b010, 5'd5), "lr_rs2_set");
    // SC and the nine AMOs
    for (int k = 0; k < 10; k++) begin
      queue_word(make_amo(amo_funct5(k), 5'd9, 5'd10, 3'b010, 5'd11), "sc_amo");
    end
    // Atomics with a width other than word
    for (int f = 0; f < 8; f++) begin
      if (f != 2) begin
        queue_word(make_amo(5'b00000, 5'd7, 5'd8, 3'(f), 5'd9), "amo_funct3");
      end
    end
    // Every funct3 for loads and stores
    for (int f = 0; f < 8; f++) begin
      queue_word(make_load(12'h7f0, 5'd3, 3'(f), 5'd4), "load");
      queue_word(make_store(12'h123, 5'd12, 5'd3, 3'(f)), "store");
    end
    // rd x0 and foreign opcodes
    queue_word(make_load(12'h004, 5'd2, 3'b010, 5'd0), "load_x0");
    queue_word(make_amo(5'b00000, 5'd1, 5'd2, 3'b010, 5'd0), "amo_x0");
    queue_word(32'h0000_0013, "other_opcode");
    queue_word(32'h0000_0000, "all_zero");
  endtask

  task automatic build_random(input int n);
    logic [31:0] w;
    int          sel;
    for (int i = 0; i < n; i++) begin
      w   = $urandom;
      sel = int'($urandom % 8);
      // Bias toward the opcodes of this stage
      if (sel < 2) begin
        w[6:0] = 7'h03;
      end else if (sel < 4) begin
        w[6:0] = 7'h23;
      end else if (sel < 7) begin
        w[6:0] = 7'h2f;
        if (($urandom % 4) != 0) w[14:12] = 3'b010;
        if (($urandom % 2) != 0) w[31:27] = amo_funct5(int'($urandom % 11));
      end
      queue_word(w, "random");
    end
  endtask

  ////////////////////////////////////////
  // Upstream driver
  ////////////////////////////////////////

  // Called 1 ns after a rising edge, returns the same way
  task automatic send_word(input logic [31:0] w, input string tname);
    logic accepted;
    while (($urandom % 4) == 0) begin
      @(posedge clk);
      #1;
    end
    instr_valid = 1'b1;
    instr_rdata = w;
    accepted    = 1'b0;
    while (!accepted) begin
      // Ready is settled by mid cycle
      @(negedge clk);
      accepted = instr_ready;
      if (accepted) begin
        exp_q.push_back(decode_ref(w));
        name_q.push_back(tname);
      end
      @(posedge clk);
      #1;
    end
    instr_valid = 1'b0;
    instr_rdata = $urandom;
  endtask

  initial begin : stimulus
    void'($urandom(32'h3fa53888));
    arst_n      = 1'b0;
    instr_valid = 1'b0;
    instr_rdata = 32'd0;
    out_ready   = 1'b0;
    build_directed();
    build_random(500);
    cycle_limit = 4 * stim_q.size() + 200;
    repeat (10) @(posedge clk);
    #1;
    arst_n = 1'b1;
    // Outputs idle after reset
    @(negedge clk);
    check_val("reset", "out_valid", 32'd0, {31'd0, out_valid});
    compare_word("reset", 31'd0, out_word);
    @(posedge clk);
    #1;
    for (int i = 0; i < stim_q.size(); i++) begin
      send_word(stim_q[i], stim_name_q[i]);
    end
    while (exp_q.size() != 0) begin
      @(posedge clk);
    end
    repeat (2) @(posedge clk);
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  // Execute stage ready toggles at random
  initial begin : ready_driver
    wait (arst_n === 1'b1);
    forever begin
      @(posedge clk);
      #1;
      out_ready = (($urandom % 10) < 7);
    end
  end

  ////////////////////////////////////////
  // Output monitor
  ////////////////////////////////////////

  always @(negedge clk) begin : monitor
    logic [30:0] exp_w;
    string       exp_n;
    if (arst_n === 1'b1) begin
      // Held word must not change or vanish
      if (hold_pending) begin
        if (out_valid !== 1'b1) begin
          errors++;
          $display("Output valid dropped before the held word was accepted");
        end else begin
          compare_word("backpressure_hold", hold_word, out_word);
        end
      end
      hold_pending = 1'b0;
      if (out_valid === 1'b1 && out_ready === 1'b0) begin
        hold_pending = 1'b1;
        hold_word    = out_word;
      end else if (out_valid === 1'b1 && out_ready === 1'b1) begin
        if (exp_q.size() == 0) begin
          errors++;
          $display("Output transfer with no instruction word in flight");
        end else begin
          exp_w = exp_q.pop_front();
          exp_n = name_q.pop_front();
          compare_word(exp_n, exp_w, out_word);
        end
      end
    end
  end

  // Run limit from the number of words
  always @(posedge clk) begin
    cycles++;
    if (cycle_limit > 0 && cycles > cycle_limit) begin
      $display("Timeout after %0d cycles, words still in flight: %0d", cycles, exp_q.size());
      $display("TB FAILED");
      $finish;
    end
  end

endmodule

//--- sim.f
+incdir+.
decode_pkg.sv
a_decoder.sv
ls_decoder.sv
decoder_merge.sv
id_mem_reg.sv
mem_decode_top.sv
tb_mem_decode_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the decode stage testbench with Verilator and run it
# Exit status is nonzero when the build fails or the log reports failure

set -o pipefail
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sim.f --top-module tb_mem_decode_top -o tb_sim \
  && ./obj_dir/tb_sim 2>&1 | tee sim.log \
  || { echo "Build or simulation run failed"; exit 1; }

grep -q "TB FAILED" sim.log && { echo "Simulation reported failure"; exit 1; } \
  || { echo "Simulation finished without failure"; exit 0; }
